/* design/ecc_pkg.sv */
package ecc_pkg;

    localparam int max_codeword_width = 32;
    localparam int max_info_width     = 26;
    localparam int syndrome_width     = 5;

    typedef logic [max_codeword_width-1:0] codeword_t;
    typedef logic [max_info_width-1:0]     info_t;
    typedef logic [1:0]                    mode_t;
    typedef logic [1:0]                    err_count_t; // 0 clean, 1 fixed, 2 uncorrectable, 3 bad mode
    typedef logic [syndrome_width-1:0]     syndrome_t;

    function automatic int info_len(input mode_t mode);
        case (mode)
            2'd0:    return 4;
            2'd1:    return 11;
            2'd2:    return 26;
            default: return 0;
        endcase
    endfunction

    function automatic int parity_len(input mode_t mode);
        case (mode)
            2'd0:    return 4;
            2'd1:    return 5;
            2'd2:    return 6;
            default: return 0;
        endcase
    endfunction

    // label of info bit idx: the (idx+1)-th non power of two from 3 upward
    function automatic syndrome_t info_label(input int idx);
        syndrome_t label;
        int        count;
        label = '0;
        count = 0;
        for (int v = 3; v < 32; v++) begin
            if ((v & (v - 1)) != 0) begin
                if (count == idx) label = syndrome_t'(v);
                count++;
            end
        end
        return label;
    endfunction

    function automatic syndrome_t hamming_parity(input mode_t mode, input info_t info);
        syndrome_t parity;
        syndrome_t label;
        int        k;
        int        r;
        parity = '0;
        k      = info_len(mode);
        r      = parity_len(mode);
        for (int i = 0; i < max_info_width; i++) begin
            label = info_label(i);
            for (int j = 0; j < syndrome_width; j++) begin
                if (i < k && j < r - 1 && label[j]) parity[j] = parity[j] ^ info[i];
            end
        end
        return parity;
    endfunction

endpackage

/* design/ecc_encoder.sv */
`timescale 1ns/1ns

module ecc_encoder (
    input  logic               clk,
    input  logic               rst,
    input  ecc_pkg::mode_t     mode,
    input  ecc_pkg::info_t     info,
    output ecc_pkg::codeword_t codeword
);

    int                 k;
    int                 r;
    ecc_pkg::info_t     info_masked;
    ecc_pkg::syndrome_t parity;
    logic               overall;
    ecc_pkg::codeword_t codeword_next;

    always_comb begin
        k = ecc_pkg::info_len(mode);
        r = ecc_pkg::parity_len(mode);
        for (int i = 0; i < ecc_pkg::max_info_width; i++) begin
            info_masked[i] = (i < k) ? info[i] : 1'b0; // drop bits beyond the code size
        end
        parity  = ecc_pkg::hamming_parity(mode, info_masked);
        overall = (^info_masked) ^ (^parity);

        codeword_next = '0;
        if (mode != 2'd3) begin
            codeword_next = (ecc_pkg::codeword_t'(info_masked) << r)
                          | ecc_pkg::codeword_t'(parity);
            codeword_next = codeword_next | (ecc_pkg::codeword_t'(overall) << (r - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            codeword <= '0;
        end else begin
            codeword <= codeword_next;
        end
    end

endmodule

/* design/ecc_syndrome.sv */
`timescale 1ns/1ns

module ecc_syndrome (
    input  logic               clk,
    input  logic               rst,
    input  ecc_pkg::codeword_t codeword_in,
    input  ecc_pkg::mode_t     mode_in,
    output ecc_pkg::codeword_t codeword,
    output ecc_pkg::syndrome_t syndrome,
    output logic               overall,
    output ecc_pkg::mode_t     mode
);

    int                 k;
    int                 r;
    ecc_pkg::info_t     rx_info;
    ecc_pkg::syndrome_t rx_hamming;
    ecc_pkg::syndrome_t syndrome_next;
    logic               overall_next;

    always_comb begin
        k = ecc_pkg::info_len(mode_in);
        r = ecc_pkg::parity_len(mode_in);
        for (int i = 0; i < ecc_pkg::max_info_width; i++) begin
            rx_info[i] = (i < k) ? codeword_in[i + r] : 1'b0;
        end
        for (int j = 0; j < ecc_pkg::syndrome_width; j++) begin
            rx_hamming[j] = (j < r - 1) ? codeword_in[j] : 1'b0; // overall bit excluded
        end
        syndrome_next = ecc_pkg::hamming_parity(mode_in, rx_info) ^ rx_hamming;

        overall_next = 1'b0;
        for (int b = 0; b < ecc_pkg::max_codeword_width; b++) begin
            if (b < k + r) overall_next = overall_next ^ codeword_in[b];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            codeword <= '0;
            syndrome <= '0;
            overall  <= 1'b0;
            mode     <= '0;
        end else begin
            codeword <= codeword_in;
            syndrome <= syndrome_next;
            overall  <= overall_next;
            mode     <= mode_in;
        end
    end

    // syndrome never reaches into the overall parity position or above
    a_syndrome_width: assert property (@(posedge clk) disable iff (rst)
        (mode == 2'd3) || ((syndrome >> (ecc_pkg::parity_len(mode) - 1)) == '0));

endmodule

/* design/ecc_corrector.sv */
`timescale 1ns/1ns

module ecc_corrector (
    input  logic                clk,
    input  logic                rst,
    input  ecc_pkg::codeword_t  codeword_in,
    input  ecc_pkg::syndrome_t  syndrome_in,
    input  logic                overall_in,
    input  ecc_pkg::mode_t      mode_in,
    output ecc_pkg::codeword_t  codeword,
    output ecc_pkg::err_count_t errors,
    output ecc_pkg::mode_t      mode
);

    int                  k;
    int                  r;
    logic                label_hit;
    ecc_pkg::codeword_t  codeword_next;
    ecc_pkg::err_count_t errors_next;

    always_comb begin
        k             = ecc_pkg::info_len(mode_in);
        r             = ecc_pkg::parity_len(mode_in);
        label_hit     = 1'b0;
        codeword_next = codeword_in;
        errors_next   = 2'd0;

        if (mode_in == 2'd3) begin
            errors_next = 2'd3;
        end else if (!overall_in) begin
            // even overall parity: clean or a double error
            errors_next = (syndrome_in == '0) ? 2'd0 : 2'd2;
        end else if (syndrome_in == '0) begin
            codeword_next = codeword_in ^ (ecc_pkg::codeword_t'(1) << (r - 1)); // overall bit
            errors_next   = 2'd1;
        end else if ((syndrome_in & (syndrome_in - ecc_pkg::syndrome_t'(1))) == '0) begin
            codeword_next = codeword_in ^ ecc_pkg::codeword_t'(syndrome_in); // hamming bit j
            errors_next   = 2'd1;
        end else begin
            for (int i = 0; i < ecc_pkg::max_info_width; i++) begin
                if (i < k && ecc_pkg::info_label(i) == syndrome_in) begin
                    codeword_next = codeword_in ^ (ecc_pkg::codeword_t'(1) << (i + r));
                    label_hit     = 1'b1;
                end
            end
            errors_next = label_hit ? 2'd1 : 2'd2; // label past the code length
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            codeword <= '0;
            errors   <= '0;
            mode     <= '0;
        end else begin
            codeword <= codeword_next;
            errors   <= errors_next;
            mode     <= mode_in;
        end
    end

    a_invalid_mode: assert property (@(posedge clk) disable iff (rst)
        (errors == 2'd3) == (mode == 2'd3));

endmodule

/* design/ecc_decoder.sv */
`timescale 1ns/1ns

module ecc_decoder (
    input  logic                clk,
    input  logic                rst,
    input  ecc_pkg::codeword_t  codeword,
    input  ecc_pkg::mode_t      mode,
    output ecc_pkg::info_t      info,
    output ecc_pkg::err_count_t errors
);

    ecc_pkg::codeword_t  syn_codeword;
    ecc_pkg::syndrome_t  syn_syndrome;
    logic                syn_overall;
    ecc_pkg::mode_t      syn_mode;
    ecc_pkg::codeword_t  cor_codeword;
    ecc_pkg::err_count_t cor_errors;
    ecc_pkg::mode_t      cor_mode;
    ecc_pkg::info_t      info_next;
    int                  k;
    int                  r;

    ecc_syndrome u_syndrome (
        .clk         (clk),
        .rst         (rst),
        .codeword_in (codeword),
        .mode_in     (mode),
        .codeword    (syn_codeword),
        .syndrome    (syn_syndrome),
        .overall     (syn_overall),
        .mode        (syn_mode)
    );

    ecc_corrector u_corrector (
        .clk         (clk),
        .rst         (rst),
        .codeword_in (syn_codeword),
        .syndrome_in (syn_syndrome),
        .overall_in  (syn_overall),
        .mode_in     (syn_mode),
        .codeword    (cor_codeword),
        .errors      (cor_errors),
        .mode        (cor_mode)
    );

    always_comb begin
        k = ecc_pkg::info_len(cor_mode); // 0 for the invalid mode
        r = ecc_pkg::parity_len(cor_mode);
        for (int i = 0; i < ecc_pkg::max_info_width; i++) begin
            info_next[i] = (i < k) ? cor_codeword[i + r] : 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            info   <= '0;
            errors <= '0;
        end else begin
            info   <= info_next;
            errors <= cor_errors;
        end
    end

    a_info_padding: assert property (@(posedge clk) disable iff (rst)
        (info >> ecc_pkg::info_len($past(cor_mode))) == '0);

endmodule

/* design/ecc_codec_top.sv */
`timescale 1ns/1ns

module ecc_codec_top (
    input  logic                clk,
    input  logic                rst,
    input  ecc_pkg::mode_t      enc_mode,
    input  ecc_pkg::info_t      enc_info,
    input  ecc_pkg::mode_t      dec_mode,
    input  ecc_pkg::codeword_t  dec_codeword,
    output ecc_pkg::codeword_t  enc_codeword,
    output ecc_pkg::info_t      dec_info,
    output ecc_pkg::err_count_t dec_errors
);

    // one cycle encode path
    ecc_encoder u_encoder (
        .clk      (clk),
        .rst      (rst),
        .mode     (enc_mode),
        .info     (enc_info),
        .codeword (enc_codeword)
    );

    // three cycle decode path
    ecc_decoder u_decoder (
        .clk      (clk),
        .rst      (rst),
        .codeword (dec_codeword),
        .mode     (dec_mode),
        .info     (dec_info),
        .errors   (dec_errors)
    );

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0; // released right after the fifth rising edge
    end

endmodule

/* bench/ecc_codec_tb.sv */
`timescale 1ns/1ns

module ecc_codec_tb;

    localparam int stim_words  = 5; // path, mode, input, expected data, expected errors
    localparam int max_vectors = 64;
    localparam int stim_depth  = max_vectors * stim_words;
    localparam int reset_limit = 20;
    localparam int drain_limit = 10;
    localparam int round_trips = 40;

    logic                clk;
    logic                rst;
    ecc_pkg::mode_t      enc_mode;
    ecc_pkg::info_t      enc_info;
    ecc_pkg::mode_t      dec_mode;
    ecc_pkg::codeword_t  dec_codeword;
    ecc_pkg::codeword_t  enc_codeword;
    ecc_pkg::info_t      dec_info;
    ecc_pkg::err_count_t dec_errors;

    logic [31:0]         stim_mem [0:stim_depth-1];
    int                  cycle;
    ecc_pkg::codeword_t  enc_exp_q[$];
    int                  enc_due_q[$];
    ecc_pkg::info_t      dec_info_q[$];
    ecc_pkg::err_count_t dec_err_q[$];
    int                  dec_due_q[$];
    ecc_pkg::mode_t      rt_mode_q[$];
    ecc_pkg::info_t      rt_info_q[$];

    clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    ecc_codec_top dut (
        .clk          (clk),
        .rst          (rst),
        .enc_mode     (enc_mode),
        .enc_info     (enc_info),
        .dec_mode     (dec_mode),
        .dec_codeword (dec_codeword),
        .enc_codeword (enc_codeword),
        .dec_info     (dec_info),
        .dec_errors   (dec_errors)
    );

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // info field width per mode: 4, 11, 26, none for the invalid mode
    function automatic ecc_pkg::info_t info_mask(input ecc_pkg::mode_t mode);
        case (mode)
            2'd0:    return 26'h000000f;
            2'd1:    return 26'h00007ff;
            2'd2:    return 26'h3ffffff;
            default: return 26'h0000000;
        endcase
    endfunction

    // advance to the next falling edge and check every result due there
    task automatic step();
        @(negedge clk);
        cycle++;
        while (enc_due_q.size() > 0 && enc_due_q[0] == cycle) begin
            check_value("enc_codeword", enc_exp_q[0], enc_codeword);
            void'(enc_due_q.pop_front());
            void'(enc_exp_q.pop_front());
        end
        while (dec_due_q.size() > 0 && dec_due_q[0] == cycle) begin
            check_value("dec_info", 32'(dec_info_q[0]), 32'(dec_info));
            check_value("dec_errors", 32'(dec_err_q[0]), 32'(dec_errors));
            void'(dec_due_q.pop_front());
            void'(dec_info_q.pop_front());
            void'(dec_err_q.pop_front());
        end
    endtask

    task automatic drive_vector(input int base);
        case (stim_mem[base])
            32'h0: begin
                enc_mode = stim_mem[base+1][1:0];
                enc_info = stim_mem[base+2][25:0];
                enc_exp_q.push_back(stim_mem[base+3]);
                enc_due_q.push_back(cycle + 1); // one cycle encode latency
            end
            32'h1: begin
                dec_mode     = stim_mem[base+1][1:0];
                dec_codeword = stim_mem[base+2];
                dec_info_q.push_back(stim_mem[base+3][25:0]);
                dec_err_q.push_back(stim_mem[base+4][1:0]);
                dec_due_q.push_back(cycle + 3);
            end
            default: stop_run("stimulus file holds an unknown path code");
        endcase
    endtask

    initial begin
        int             vec;
        int             waited;
        int             trips;
        ecc_pkg::mode_t rt_mode;
        ecc_pkg::info_t rt_info;

        void'($urandom(85065));
        cycle        = 0;
        enc_mode     = 2'd2; // nonzero inputs while reset is held
        enc_info     = '1;
        dec_mode     = 2'd1;
        dec_codeword = '1;
        for (int a = 0; a < stim_depth; a++) begin
            stim_mem[a] = {12'hbad, 20'(a)};
        end
        $readmemh("bench/ecc_stimulus.txt", stim_mem);

        waited = 0;
        do begin
            step();
            waited++;
            if (waited > reset_limit) stop_run("reset was never released");
            check_value("enc_codeword", 32'h0, enc_codeword);
            check_value("dec_info", 32'h0, 32'(dec_info));
            check_value("dec_errors", 32'h0, 32'(dec_errors));
        end while (rst);

        vec = 0;
        while (vec < max_vectors && stim_mem[vec * stim_words] != 32'hf) begin
            step();
            drive_vector(vec * stim_words);
            vec++;
        end
        if (vec == max_vectors) stop_run("stimulus file has no end marker");

        // encode random info, then feed each codeword straight back into the decoder
        trips = 0;
        while (trips < round_trips || rt_mode_q.size() > 0) begin
            step();
            if (rt_mode_q.size() > 0) begin
                rt_mode      = rt_mode_q.pop_front();
                rt_info      = rt_info_q.pop_front();
                dec_mode     = rt_mode;
                dec_codeword = enc_codeword;
                dec_info_q.push_back(rt_info & info_mask(rt_mode));
                dec_err_q.push_back(2'd0);
                dec_due_q.push_back(cycle + 3);
            end
            if (trips < round_trips) begin
                rt_mode  = ecc_pkg::mode_t'($urandom_range(2, 0));
                rt_info  = ecc_pkg::info_t'($urandom);
                enc_mode = rt_mode;
                enc_info = rt_info;
                rt_mode_q.push_back(rt_mode);
                rt_info_q.push_back(rt_info);
                trips++;
            end
        end

        waited = 0;
        while (enc_due_q.size() > 0 || dec_due_q.size() > 0) begin
            step();
            waited++;
            if (waited > drain_limit) stop_run("results were still pending after the drain");
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

/* vlog.f */
design/ecc_pkg.sv
design/ecc_encoder.sv
design/ecc_syndrome.sv
design/ecc_corrector.sv
design/ecc_decoder.sv
design/ecc_codec_top.sv
bench/clock_gen.sv
bench/ecc_codec_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ECC codec testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f vlog.f --top-module ecc_codec_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vecc_codec_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi

/* bench/ecc_stimulus.txt */
// columns: path mode input expected_data expected_errors, all hex
// path 0 encodes info, path 1 decodes a codeword, path f ends the list
0 0 0000005 00000055 0
0 0 000000b 000000b1 0
0 0 000000f 000000ff 0
0 0 3fffff5 00000055 0
0 1 00005a3 0000b472 0
0 1 00007ff 0000ffff 0
0 1 3fffda3 0000b472 0
0 2 0000001 00000063 0
0 2 0000800 00020031 0
0 2 2000000 8000001f 0
0 2 3ffffff ffffffff 0
0 3 3ffffff 00000000 0
1 0 00000055 0000005 0
1 0 000000b1 000000b 0
1 0 00000015 0000005 1
1 0 00000057 0000005 1
1 0 0000005d 0000005 1
1 0 00000014 0000001 2
1 1 0000b472 00005a3 0
1 1 0000b672 00005a3 1
1 1 0000b47a 00005a3 1
1 1 0000b462 00005a3 1
1 1 00003452 00001a2 2
1 2 00020031 0000800 0
1 2 8000001f 2000000 0
1 2 7fffffff 3ffffff 1
1 2 00000073 0000001 1
1 2 00000043 0000001 1
1 2 00020063 0000001 1
1 2 8000001c 2000000 2
1 3 12345678 0000000 3
f 0 0 0 0
